// File: verilog/radio_pkg.sv
package radio_pkg;

   ////////////////////
   // widths
   localparam int ADC_W      = 12;   // converter word
   localparam int SAMPLE_W   = 16;   // dsp sample
   localparam int SET_DATA_W = 32;   // settings payload
   localparam int MAX_CHANS  = 4;    // limited by chan_id_t

   typedef logic        [ADC_W-1:0]    adc_word_t;
   typedef logic signed [SAMPLE_W-1:0] sample_t;
   typedef logic        [1:0]          chan_id_t;
   typedef logic        [2:0]          decim_t;     // log2 of averaging length
   typedef logic        [7:0]          set_addr_t;

   // one complex sample, i in the upper half
   typedef struct packed {
      sample_t i;
      sample_t q;
   } iq_t;

   // single cycle write strobe, no handshake
   typedef struct packed {
      logic                  stb;
      set_addr_t             addr;
      logic [SET_DATA_W-1:0] data;
   } set_bus_t;

   ////////////////////
   // 36 bit rx stream word toward the host side
   typedef struct packed {
      chan_id_t chan;    // source channel
      logic     ovf;     // results were dropped before this word
      logic     rsvd;    // always zero
      iq_t      iq;
   } rx_word_t;

   // channel n sits at SET_BASE + n
   localparam set_addr_t SET_BASE = 8'h10;

endpackage

// File: verilog/adc_capture.sv
`timescale 1ns/10ps

module adc_capture
(
   input  logic                 clk_fpga,
   input  logic                 rst,
   input  radio_pkg::adc_word_t adc_i,
   input  radio_pkg::adc_word_t adc_q,
   output radio_pkg::iq_t       adc_iq
);
   import radio_pkg::*;

   adc_word_t inv_i;
   adc_word_t inv_q;

   // board routes both buses inverted
   assign inv_i = ~adc_i;
   assign inv_q = ~adc_q;

   // two's complement 12b up to sample width
   function automatic sample_t sext(input adc_word_t w);
      return sample_t'({{(SAMPLE_W-ADC_W){w[ADC_W-1]}}, w});
   endfunction

   ////////////////////
   // one register stage, value visible one cycle later
   always_ff @(posedge clk_fpga)
   begin
      if (rst)
      begin
         adc_iq <= '0;
      end
      else
      begin
         adc_iq.i <= sext(inv_i);   // DA
         adc_iq.q <= sext(inv_q);   // DB
      end
   end

endmodule

// File: verilog/rx_dsp_chan.sv
`timescale 1ns/10ps

module rx_dsp_chan
#(
   parameter radio_pkg::set_addr_t CHAN_ADDR = 8'h10
)
(
   input  logic                clk_fpga,
   input  logic                rst,
   input  radio_pkg::set_bus_t set_bus,
   input  radio_pkg::iq_t      adc_iq,
   output radio_pkg::iq_t      smp_data,
   output logic                smp_ovf,
   output logic                smp_valid,
   input  logic                smp_take,
   output logic                running
);
   import radio_pkg::*;

   typedef logic signed [18:0] acc_t;          // 12b inputs, up to 128 per group
   typedef enum logic {IDLE, ACCUM} state_t;

   ////////////////////
   // control register
   logic   run;
   decim_t decim;

   always_ff @(posedge clk_fpga)
   begin
      if (rst)
      begin
         run   <= 1'b0;
         decim <= '0;
      end
      else if (set_bus.stb && (set_bus.addr == CHAN_ADDR))   // own address only
      begin
         run   <= set_bus.data[0];
         decim <= decim_t'(set_bus.data[3:1]);
      end
   end

   assign running = run;

   ////////////////////
   // averaging decimator
   state_t     state;
   logic [6:0] grp_cnt;     // samples already in acc
   logic [6:0] grp_last;
   acc_t       acc_i;
   acc_t       acc_q;
   acc_t       sum_i;
   acc_t       sum_q;
   logic       grp_done;
   iq_t        avg;

   assign grp_last = (7'd1 << decim) - 7'd1;   // wraps to 127 for decim 7
   assign sum_i    = acc_i + acc_t'(adc_iq.i);
   assign sum_q    = acc_q + acc_t'(adc_iq.q);
   assign grp_done = (state == ACCUM) && run && (grp_cnt >= grp_last);

   // arithmetic shift gives floor of the mean
   assign avg.i = sample_t'(sum_i >>> decim);
   assign avg.q = sample_t'(sum_q >>> decim);

   always_ff @(posedge clk_fpga)
   begin
      if (rst)
      begin
         state   <= IDLE;
         grp_cnt <= '0;
         acc_i   <= '0;
         acc_q   <= '0;
      end
      else
      begin
         case (state)
            IDLE:
            begin
               grp_cnt <= '0;
               acc_i   <= '0;
               acc_q   <= '0;
               if (run)
                  state <= ACCUM;   // first sample on next cycle
            end
            ACCUM:
            begin
               if (!run)
               begin
                  state   <= IDLE;   // group count restarts
                  grp_cnt <= '0;
                  acc_i   <= '0;
                  acc_q   <= '0;
               end
               else if (grp_done)
               begin
                  grp_cnt <= '0;     // result leaves via avg
                  acc_i   <= '0;
                  acc_q   <= '0;
               end
               else
               begin
                  grp_cnt <= grp_cnt + 7'd1;
                  acc_i   <= sum_i;
                  acc_q   <= sum_q;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   ////////////////////
   // one entry output buffer
   logic buf_valid;
   logic buf_load;
   logic buf_drop;
   logic ovf_flag;
   iq_t  buf_data;

   assign buf_load = grp_done && (!buf_valid || smp_take);   // slot free or freeing
   assign buf_drop = grp_done && buf_valid && !smp_take;

   always_ff @(posedge clk_fpga)
   begin
      if (rst)
      begin
         buf_valid <= 1'b0;
         ovf_flag  <= 1'b0;
      end
      else
      begin
         if (buf_load)
            buf_valid <= 1'b1;
         else if (smp_take)
            buf_valid <= 1'b0;

         if (buf_drop)
            ovf_flag <= 1'b1;   // sticky until the next word leaves
         else if (smp_take)
            ovf_flag <= 1'b0;
      end
   end

   always_ff @(posedge clk_fpga)
   begin
      if (buf_load)
         buf_data <= avg;
   end

   assign smp_data  = buf_data;
   assign smp_valid = buf_valid;
   assign smp_ovf   = ovf_flag;

endmodule

// File: verilog/rx_stream_mux.sv
`timescale 1ns/10ps

module rx_stream_mux
#(
   parameter int NUM_CHANS = 2
)
(
   input  logic                 clk_fpga,
   input  logic                 rst,
   input  radio_pkg::iq_t       smp_data [NUM_CHANS],
   input  logic [NUM_CHANS-1:0] smp_ovf,
   input  logic [NUM_CHANS-1:0] smp_valid,
   output logic [NUM_CHANS-1:0] smp_take,
   output radio_pkg::rx_word_t  rx_data,
   output logic                 rx_src_rdy,
   input  logic                 rx_dst_rdy
);
   import radio_pkg::*;

   chan_id_t last_grant;
   chan_id_t idx_hi;        // first requester above last grant
   chan_id_t idx_lo;        // first requester at or below it
   chan_id_t grant_idx;
   logic     found_hi;
   logic     found_lo;
   logic     out_free;
   logic     grant_ok;
   rx_word_t grant_word;

   // output reg empty or draining this cycle
   assign out_free = !rx_src_rdy || rx_dst_rdy;

   ////////////////////
   // round robin search, wraps past the last grant
   always_comb
   begin
      found_hi = 1'b0;
      found_lo = 1'b0;
      idx_hi   = '0;
      idx_lo   = '0;
      for (int c = 0; c < NUM_CHANS; c++)
      begin
         if (smp_valid[c] && (chan_id_t'(c) > last_grant) && !found_hi)
         begin
            found_hi = 1'b1;
            idx_hi   = chan_id_t'(c);
         end
         if (smp_valid[c] && (chan_id_t'(c) <= last_grant) && !found_lo)
         begin
            found_lo = 1'b1;
            idx_lo   = chan_id_t'(c);
         end
      end
   end

   assign grant_ok  = out_free && (found_hi || found_lo);
   assign grant_idx = found_hi ? idx_hi : idx_lo;

   // word build and one-hot take
   always_comb
   begin
      grant_word      = '0;   // rsvd stays zero
      grant_word.chan = grant_idx;
      for (int c = 0; c < NUM_CHANS; c++)
      begin
         smp_take[c] = grant_ok && (chan_id_t'(c) == grant_idx);
         if (chan_id_t'(c) == grant_idx)
         begin
            grant_word.ovf = smp_ovf[c];
            grant_word.iq  = smp_data[c];
         end
      end
   end

   ////////////////////
   // output register
   always_ff @(posedge clk_fpga)
   begin
      if (rst)
      begin
         rx_src_rdy <= 1'b0;
         last_grant <= chan_id_t'(NUM_CHANS - 1);   // chan 0 first
      end
      else if (out_free)
      begin
         rx_src_rdy <= grant_ok;
         if (grant_ok)
            last_grant <= grant_idx;
      end
   end

   always_ff @(posedge clk_fpga)
   begin
      if (grant_ok)
         rx_data <= grant_word;   // held while stalled
   end

endmodule

// File: verilog/radio_rx_core.sv
`timescale 1ns/10ps

module radio_rx_core
#(
   parameter int NUM_CHANS = 2
)
(
   input  logic                 clk_fpga,
   input  logic                 rst,
   input  radio_pkg::adc_word_t adc_i,        // DA
   input  radio_pkg::adc_word_t adc_q,        // DB
   input  radio_pkg::set_bus_t  set_bus,
   output radio_pkg::rx_word_t  rx_data,
   output logic                 rx_src_rdy,
   input  logic                 rx_dst_rdy,
   output logic [NUM_CHANS-1:0] rx_running
);
   import radio_pkg::*;

   if ((NUM_CHANS < 1) || (NUM_CHANS > MAX_CHANS))
   begin : gen_bad_chans
      $error("radio_rx_core: NUM_CHANS out of range");
   end

   iq_t                  adc_iq;
   iq_t                  smp_data [NUM_CHANS];
   logic [NUM_CHANS-1:0] smp_ovf;
   logic [NUM_CHANS-1:0] smp_valid;
   logic [NUM_CHANS-1:0] smp_take;

   ////////////////////
   // adc front end, shared by all channels
   adc_capture adc_capture_inst
   (
      .clk_fpga (clk_fpga),
      .rst      (rst),
      .adc_i    (adc_i),
      .adc_q    (adc_q),
      .adc_iq   (adc_iq)
   );

   ////////////////////
   // dsp channels, one settings address each
   for (genvar g = 0; g < NUM_CHANS; g++)
   begin : gen_chan
      rx_dsp_chan #(
         .CHAN_ADDR (SET_BASE + set_addr_t'(g))
      ) rx_dsp_chan_inst (
         .clk_fpga  (clk_fpga),
         .rst       (rst),
         .set_bus   (set_bus),
         .adc_iq    (adc_iq),
         .smp_data  (smp_data[g]),
         .smp_ovf   (smp_ovf[g]),
         .smp_valid (smp_valid[g]),
         .smp_take  (smp_take[g]),
         .running   (rx_running[g])
      );
   end

   // merge into the 36 bit stream
   rx_stream_mux #(
      .NUM_CHANS (NUM_CHANS)
   ) rx_stream_mux_inst (
      .clk_fpga   (clk_fpga),
      .rst        (rst),
      .smp_data   (smp_data),
      .smp_ovf    (smp_ovf),
      .smp_valid  (smp_valid),
      .smp_take   (smp_take),
      .rx_data    (rx_data),
      .rx_src_rdy (rx_src_rdy),
      .rx_dst_rdy (rx_dst_rdy)
   );

endmodule

// File: sim/radio_rx_core_chk.sv
`timescale 1ns/10ps

module radio_rx_core_chk
#(
   parameter int NUM_CHANS = 2
)
(
   input logic                clk_fpga,
   input logic                rst,
   input radio_pkg::rx_word_t rx_data,
   input logic                rx_src_rdy,
   input logic                rx_dst_rdy
);

   ////////////////////
   // stream port rules
   a_rst_quiet: assert property (@(posedge clk_fpga) rst |=> !rx_src_rdy)
      else $error("rx_src_rdy high one cycle into reset");

   // word held while the sink stalls
   a_hold_on_stall: assert property (@(posedge clk_fpga) disable iff (rst)
      rx_src_rdy && !rx_dst_rdy |=> rx_src_rdy && $stable(rx_data))
      else $error("rx_data changed or rx_src_rdy dropped under stall");

   a_chan_range: assert property (@(posedge clk_fpga) disable iff (rst)
      rx_src_rdy |-> (32'(rx_data.chan) < NUM_CHANS))
      else $error("rx_data.chan beyond the channel count");

   a_rsvd_zero: assert property (@(posedge clk_fpga) disable iff (rst)
      rx_src_rdy |-> !rx_data.rsvd)
      else $error("rx_data.rsvd set");

endmodule

bind radio_rx_core radio_rx_core_chk #(
   .NUM_CHANS (NUM_CHANS)
) radio_rx_core_chk_inst (
   .clk_fpga   (clk_fpga),
   .rst        (rst),
   .rx_data    (rx_data),
   .rx_src_rdy (rx_src_rdy),
   .rx_dst_rdy (rx_dst_rdy)
);

// File: sim/tb_radio_rx_core.sv
`timescale 1ns/10ps

module tb_radio_rx_core;
   import radio_pkg::*;

   localparam int NUM_CHANS  = 2;
   localparam int MAX_CYCLES = 6000;   // tests take about 1500
   localparam int WIN        = 800;    // rate window, multiple of 8

   logic                 clk_fpga = 1'b0;
   logic                 rst;
   adc_word_t            adc_i = '0;
   adc_word_t            adc_q = '0;
   set_bus_t             set_bus;
   rx_word_t             rx_data;
   logic                 rx_src_rdy;
   logic                 rx_dst_rdy;
   logic [NUM_CHANS-1:0] rx_running;

   adc_word_t pat_i [2];           // adc pair a and b
   adc_word_t pat_q [2];
   logic      pat_alt;             // alternate a/b every cycle
   logic      pat_ph = 1'b0;
   rx_word_t  got_q [$];           // every word that transferred
   int        mark;                // first word of the running test
   int        cycle_cnt = 0;

   radio_rx_core #(
      .NUM_CHANS (NUM_CHANS)
   ) radio_rx_core_inst (
      .clk_fpga   (clk_fpga),
      .rst        (rst),
      .adc_i      (adc_i),
      .adc_q      (adc_q),
      .set_bus    (set_bus),
      .rx_data    (rx_data),
      .rx_src_rdy (rx_src_rdy),
      .rx_dst_rdy (rx_dst_rdy),
      .rx_running (rx_running)
   );

   always #5 clk_fpga = ~clk_fpga;   // 100 MHz

   ////////////////////
   // adc source and stream monitor
   always @(posedge clk_fpga)
   begin
      adc_i  <= (pat_alt && pat_ph) ? pat_i[1] : pat_i[0];
      adc_q  <= (pat_alt && pat_ph) ? pat_q[1] : pat_q[0];
      pat_ph <= ~pat_ph;
   end

   always @(negedge clk_fpga)
   begin
      if (!rst && rx_src_rdy && rx_dst_rdy)
         got_q.push_back(rx_data);   // transfers on the next rising edge
   end

   always @(posedge clk_fpga)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES)
      begin
         $display("timeout: tests did not complete within %0d cycles", MAX_CYCLES);
         $display("Finished with errors");
         $fatal(1, "run stopped by the cycle limit");
      end
   end

   ////////////////////
   // reference model
   // bus is inverted on the board, then read as 12b two's complement
   function automatic int inv_value(input adc_word_t w);
      return -int'($signed(w)) - 1;
   endfunction

   function automatic int mean_value(input adc_word_t a, input adc_word_t b);
      int s;
      s = inv_value(a) + inv_value(b);
      return s >>> 1;   // floor
   endfunction

   function automatic set_addr_t chan_addr(input int n);
      return SET_BASE + set_addr_t'(n);
   endfunction

   function automatic adc_word_t rnd_adc();
      return adc_word_t'($urandom());
   endfunction

   ////////////////////
   // helpers
   task automatic check_eq(input string what, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp)
      begin
         $display("CHECK FAILED at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
         $display("Finished with errors");
         $fatal(1, "stopped at the first mismatch");
      end
   endtask

   task automatic check_word(input rx_word_t w, input logic ovf, input sample_t ei,
                             input sample_t eq);
      check_eq("ovf", 64'(w.ovf), 64'(ovf));
      check_eq("rsvd", 64'(w.rsvd), 64'(0));
      check_eq("i sample", 64'(w.iq.i), 64'(ei));
      check_eq("q sample", 64'(w.iq.q), 64'(eq));
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge clk_fpga);
   endtask

   // one strobe cycle, unused data bits random
   task automatic set_write(input set_addr_t addr, input logic run, input decim_t decim);
      logic [31:0] junk;
      junk = $urandom();
      @(posedge clk_fpga);
      set_bus.stb  <= 1'b1;
      set_bus.addr <= addr;
      set_bus.data <= {junk[31:4], decim, run};
      @(posedge clk_fpga);
      set_bus.stb  <= 1'b0;
   endtask

   task automatic drive_adc(input adc_word_t ai, input adc_word_t aq, input adc_word_t bi,
                            input adc_word_t bq, input logic alt);
      @(posedge clk_fpga);
      pat_i[0] <= ai;
      pat_q[0] <= aq;
      pat_i[1] <= bi;
      pat_q[1] <= bq;
      pat_alt  <= alt;
      wait_cycles(4);   // pattern now in the capture reg
   endtask

   task automatic collect(input int n);
      while (got_q.size() - mark < n)
         @(posedge clk_fpga);
   endtask

   task automatic stop_all();
      for (int c = 0; c < NUM_CHANS; c++)
         set_write(chan_addr(c), 1'b0, 3'd0);
      wait_cycles(20);   // drain leftovers
   endtask

   ////////////////////
   // directed tests
   task automatic test_idle();
      drive_adc(rnd_adc(), rnd_adc(), rnd_adc(), rnd_adc(), 1'b1);
      repeat (100)
      begin
         @(negedge clk_fpga);
         check_eq("rx_src_rdy with no channel running", 64'(rx_src_rdy), 64'(0));
         check_eq("rx_running after reset", 64'(rx_running), 64'(0));
      end
   endtask

   task automatic test_passthrough();
      adc_word_t ai;
      adc_word_t aq;
      ai = rnd_adc();
      aq = rnd_adc();
      drive_adc(ai, aq, ai, aq, 1'b0);
      mark = got_q.size();
      set_write(chan_addr(0), 1'b1, 3'd0);
      collect(32);
      for (int k = mark; k < got_q.size(); k++)
      begin
         check_eq("decim 0 chan", 64'(got_q[k].chan), 64'(0));
         check_word(got_q[k], 1'b0, sample_t'(inv_value(ai)), sample_t'(inv_value(aq)));
      end
      stop_all();
   endtask

   task automatic test_average();
      adc_word_t ai;
      adc_word_t aq;
      adc_word_t bi;
      adc_word_t bq;
      int        cnt [NUM_CHANS];
      ai = rnd_adc();
      aq = rnd_adc();
      bi = rnd_adc();
      bq = rnd_adc();
      foreach (cnt[c])
         cnt[c] = 0;
      drive_adc(ai, aq, bi, bq, 1'b1);
      set_write(chan_addr(0), 1'b1, 3'd1);
      set_write(chan_addr(1), 1'b1, 3'd3);
      wait_cycles(20);   // past startup
      mark = got_q.size();
      wait_cycles(WIN);
      for (int k = mark; k < got_q.size(); k++)
      begin
         check_eq("chan in range", 64'(int'(got_q[k].chan) < NUM_CHANS), 64'(1));
         cnt[got_q[k].chan]++;
         check_word(got_q[k], 1'b0, sample_t'(mean_value(ai, bi)),
                    sample_t'(mean_value(aq, bq)));
      end
      check_eq($sformatf("chan 0 count %0d near %0d", cnt[0], WIN / 2),
               64'((cnt[0] >= WIN / 2 - 1) && (cnt[0] <= WIN / 2 + 1)), 64'(1));
      check_eq($sformatf("chan 1 count %0d near %0d", cnt[1], WIN / 8),
               64'((cnt[1] >= WIN / 8 - 1) && (cnt[1] <= WIN / 8 + 1)), 64'(1));
      stop_all();
   endtask

   task automatic test_overflow();
      adc_word_t            ai;
      adc_word_t            aq;
      adc_word_t            bi;
      adc_word_t            bq;
      logic [NUM_CHANS-1:0] seen;
      ai   = rnd_adc();
      aq   = rnd_adc();
      bi   = rnd_adc();
      bq   = rnd_adc();
      seen = '0;
      drive_adc(ai, aq, bi, bq, 1'b1);
      @(posedge clk_fpga);
      rx_dst_rdy <= 1'b0;
      set_write(chan_addr(0), 1'b1, 3'd2);
      set_write(chan_addr(1), 1'b1, 3'd2);
      mark = got_q.size();
      wait_cycles(40);
      @(negedge clk_fpga);
      check_eq("rx_src_rdy held under stall", 64'(rx_src_rdy), 64'(1));
      @(posedge clk_fpga);
      rx_dst_rdy <= 1'b1;
      collect(9);
      // chan 0 filled the output reg before any drop
      check_eq("first word after stall chan", 64'(got_q[mark].chan), 64'(0));
      check_word(got_q[mark], 1'b0, sample_t'(mean_value(ai, bi)),
                 sample_t'(mean_value(aq, bq)));
      for (int k = mark + 1; k < got_q.size(); k++)
      begin
         check_eq("chan in range", 64'(int'(got_q[k].chan) < NUM_CHANS), 64'(1));
         check_word(got_q[k], !seen[got_q[k].chan], sample_t'(mean_value(ai, bi)),
                    sample_t'(mean_value(aq, bq)));
         seen[got_q[k].chan] = 1'b1;
      end
      check_eq("both chans delivered after stall", 64'(seen), 64'({NUM_CHANS{1'b1}}));
      stop_all();
   endtask

   task automatic test_stop();
      int cnt [NUM_CHANS];
      foreach (cnt[c])
         cnt[c] = 0;
      drive_adc(rnd_adc(), rnd_adc(), rnd_adc(), rnd_adc(), 1'b0);
      mark = got_q.size();
      set_write(chan_addr(0), 1'b1, 3'd1);
      set_write(chan_addr(1), 1'b1, 3'd2);
      collect(6);
      set_write(chan_addr(0), 1'b0, 3'd0);
      set_write(chan_addr(1), 1'b0, 3'd0);
      @(posedge clk_fpga);   // output reg word leaves here
      mark = got_q.size();
      wait_cycles(50);
      for (int k = mark; k < got_q.size(); k++)
         cnt[got_q[k].chan]++;
      check_eq("chan 0 words after stop", 64'(cnt[0] <= 1), 64'(1));
      check_eq("chan 1 words after stop", 64'(cnt[1] <= 1), 64'(1));
      repeat (20)
      begin
         @(negedge clk_fpga);
         check_eq("rx_src_rdy after stop", 64'(rx_src_rdy), 64'(0));
         check_eq("rx_running after stop", 64'(rx_running), 64'(0));
      end
   endtask

   task automatic test_bad_addr();
      mark = got_q.size();
      set_write(chan_addr(3), 1'b1, 3'd0);   // no channel there
      repeat (50)
      begin
         @(negedge clk_fpga);
         check_eq("rx_running after unused address", 64'(rx_running), 64'(0));
      end
      check_eq("words after unused address", 64'(got_q.size() - mark), 64'(0));
   endtask

   initial
   begin
      void'($urandom(87979));
      rst        = 1'b1;
      set_bus    = '0;
      rx_dst_rdy = 1'b1;
      pat_i      = '{default: '0};
      pat_q      = '{default: '0};
      pat_alt    = 1'b0;
      mark       = 0;
      repeat (10) @(posedge clk_fpga);
      rst <= 1'b0;
      test_idle();
      test_passthrough();
      test_average();
      test_overflow();
      test_stop();
      test_bad_addr();
      $display("Finished with no errors");
      $finish;
   end

endmodule

// File: radio_rx_core.f
verilog/radio_pkg.sv
verilog/adc_capture.sv
verilog/rx_dsp_chan.sv
verilog/rx_stream_mux.sv
verilog/radio_rx_core.sv
sim/radio_rx_core_chk.sv
sim/tb_radio_rx_core.sv

// File: run_sim.sh
#!/bin/sh
# build and run the radio_rx_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_radio_rx_core
LOG=sim.log
FAIL_MSG="Finished with errors"
PASS_MSG="Finished with no errors"

verilator --binary --timing --assert -j 0 --top-module "$TOP" -f radio_rx_core.f
if [ $? -ne 0 ]; then
   echo "RESULT: FAIL (compile)"
   exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "$FAIL_MSG" "$LOG"; then
   echo "RESULT: FAIL"
   exit 1
fi

# an assertion or crash ends the run without a verdict line
if [ "$run_status" -ne 0 ] || ! grep -q "$PASS_MSG" "$LOG"; then
   echo "RESULT: FAIL (simulation ended early, status $run_status)"
   exit 1
fi

echo "RESULT: PASS"
exit 0
